//--- common/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// --------------------------------------------------
// clock and line rate
// --------------------------------------------------

`define UART_CLKFREQ 10_000_000 // system clock in hz.
`define UART_BAUD    625_000    // gives 16 clocks per bit.

// --------------------------------------------------
// buffering and identification
// --------------------------------------------------

`define UART_FIFO_DEPTH 4 // entries in each direction.

`define UART_IDENT 32'hbeef0023 // low two bits are overlaid with the enables.

`endif

//--- common/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // --------------------------------------------------
  // receive fifo entry
  // --------------------------------------------------

  typedef struct packed {
    logic       frame_err; // stop bit was sampled low.
    logic [7:0] data;
  } rx_entry_t;

  // --------------------------------------------------
  // status word, address 0
  // --------------------------------------------------

  localparam int unsigned RX_DATA_LSB = 0;
  localparam int unsigned RX_DATA_MSB = 7;
  localparam int unsigned RX_FERR     = 8;
  localparam int unsigned RX_VALID    = 9;
  localparam int unsigned TX_FULL     = 10;
  localparam int unsigned TX_IDLE     = 11;
  localparam int unsigned RX_OVF      = 12; // sticky until cleared.

  // --------------------------------------------------
  // control register, address 1
  // --------------------------------------------------

  localparam int unsigned IE_RX   = 0;
  localparam int unsigned IE_TX   = 1;
  localparam int unsigned OVF_CLR = 8; // write-only and read back as an ident bit.

endpackage

`default_nettype wire

//--- verilog/uart_fifo.sv
`default_nettype none

module uart_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     push,
  input  wire payload_t wdata,
  input  wire logic     pop,
  output payload_t      head,
  output logic          empty,
  output logic          full
);

  localparam int AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNTW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   rd_ptr;
  logic [AW-1:0]   wr_ptr;
  logic [CNTW-1:0] count;
  logic            do_push;
  logic            do_pop;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;
  assign empty   = (count == '0);
  assign full    = (count == CNTW'(DEPTH));
  assign head    = mem[rd_ptr]; // oldest entry, visible without a pop.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`default_nettype none

module uart_tx #(
  parameter int CLKFREQ = 10_000_000,
  parameter int BAUD    = 625_000
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       start,
  input  wire logic [7:0] data,
  output logic            ready,
  output logic            tx
);

  localparam int DIV = CLKFREQ / BAUD;
  localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

  logic [CW-1:0] baud_cnt;
  logic [3:0]    bit_cnt;
  logic [9:0]    shreg;
  logic          busy;

  assign ready = ~busy;
  assign tx    = shreg[0]; // shifts in ones, so the line idles high.

  // --------------------------------------------------
  // frame sequencer
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shreg    <= '1;
    end else if (!busy) begin
      if (start) begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
        shreg    <= {1'b1, data, 1'b0}; // stop, data lsb first, start.
      end
    end else begin
      if (baud_cnt == CW'(DIV - 1)) begin
        baud_cnt <= '0;
        bit_cnt  <= bit_cnt + 4'd1;
        shreg    <= {1'b1, shreg[9:1]};
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end

      // ready rises in the last stop bit cycle.
      // A queued byte then starts right after the stop bit.
      if (bit_cnt == 4'd9 && baud_cnt == CW'(DIV - 2)) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
`default_nettype none

module uart_rx #(
  parameter int CLKFREQ = 10_000_000,
  parameter int BAUD    = 625_000
) (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          rx,
  output logic               strobe,
  output uart_pkg::rx_entry_t entry
);

  localparam int DIV = CLKFREQ / BAUD;
  localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } state_t;

  state_t        state;
  logic [1:0]    sync;
  logic          rx_s;
  logic          rx_prev;
  logic [CW-1:0] baud_cnt;
  logic [2:0]    bit_cnt;
  logic [7:0]    shreg;
  logic          half_tick;
  logic          bit_tick;

  assign rx_s      = sync[1];
  assign half_tick = (baud_cnt == CW'(DIV / 2 - 1));
  assign bit_tick  = (baud_cnt == CW'(DIV - 1));

  // --------------------------------------------------
  // synchronizer and frame control
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync     <= 2'b11;
      rx_prev  <= 1'b1;
      state    <= S_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      strobe   <= 1'b0;
    end else begin
      sync     <= {sync[0], rx};
      rx_prev  <= rx_s;
      strobe   <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        S_IDLE: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_s) state <= S_START; // falling edge only.
        end
        S_START: begin
          if (half_tick) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s ? S_IDLE : S_DATA; // high again means a glitch.
          end
        end
        S_DATA: begin
          if (bit_tick) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= S_STOP;
          end
        end
        default: begin
          if (bit_tick) begin
            strobe <= 1'b1;
            state  <= S_IDLE;
          end
        end
      endcase
    end
  end

  // --------------------------------------------------
  // sampled data
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (state == S_DATA && bit_tick) shreg <= {rx_s, shreg[7:1]};
    if (state == S_STOP && bit_tick) begin
      entry.data      <= shreg;
      entry.frame_err <= ~rx_s;
    end
  end

endmodule

`default_nettype wire

//--- uart/uart_regs.sv
`default_nettype none

`include "uart_settings.svh"

module uart_regs (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                select,
  input  wire logic                write,
  input  wire logic                address,
  input  wire logic [3:0]          be,
  input  wire logic [31:0]         data_in,
  output logic      [31:0]         data_out,
  output logic      [1:0]          interrupt,
  input  wire logic [7:0]          tx_head,
  input  wire logic                tx_empty,
  input  wire logic                tx_full,
  output logic                     tx_push,
  output logic                     tx_pop,
  output logic      [7:0]          tx_wdata,
  input  wire uart_pkg::rx_entry_t rx_head,
  input  wire logic                rx_empty,
  input  wire logic                rx_full,
  output logic                     rx_push,
  output logic                     rx_pop,
  output uart_pkg::rx_entry_t      rx_wdata,
  input  wire logic                tx_ready,
  output logic                     tx_start,
  input  wire logic                rx_strobe,
  input  wire uart_pkg::rx_entry_t rx_entry
);

  logic        wr_acc;
  logic        rd_acc;
  logic        ie_rx;
  logic        ie_tx;
  logic        rx_ovf;
  logic        tx_idle;
  logic [31:0] status_word;
  logic [31:0] ident_word;

  assign wr_acc = select & write;
  assign rd_acc = select & ~write;

  // --------------------------------------------------
  // fifo strobes and transmitter start
  // --------------------------------------------------

  assign tx_push  = wr_acc & ~address & be[0]; // dropped by the fifo when full.
  assign tx_wdata = data_in[7:0];
  assign tx_start = tx_ready & ~tx_empty;
  assign tx_pop   = tx_start; // tx_head is the byte latched by the transmitter.
  assign rx_pop   = rd_acc & ~address;
  assign rx_push  = rx_strobe;
  assign rx_wdata = rx_entry;
  assign tx_idle  = tx_empty & tx_ready;

  // --------------------------------------------------
  // control state
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ie_rx  <= 1'b0;
      ie_tx  <= 1'b0;
      rx_ovf <= 1'b0;
    end else begin
      if (wr_acc && address && be[0]) begin
        ie_rx <= data_in[uart_pkg::IE_RX];
        ie_tx <= data_in[uart_pkg::IE_TX];
        if (data_in[uart_pkg::OVF_CLR]) rx_ovf <= 1'b0;
      end
      if (rx_strobe && rx_full) rx_ovf <= 1'b1; // a new loss wins over a clear.
    end
  end

  // --------------------------------------------------
  // read data
  // --------------------------------------------------

  always_comb begin
    status_word = '0;
    status_word[uart_pkg::RX_DATA_MSB:uart_pkg::RX_DATA_LSB] = rx_head.data;
    status_word[uart_pkg::RX_FERR]  = rx_head.frame_err;
    status_word[uart_pkg::RX_VALID] = ~rx_empty;
    status_word[uart_pkg::TX_FULL]  = tx_full;
    status_word[uart_pkg::TX_IDLE]  = tx_idle;
    status_word[uart_pkg::RX_OVF]   = rx_ovf;
  end

  always_comb begin
    ident_word = `UART_IDENT;
    ident_word[uart_pkg::IE_RX] = ie_rx;
    ident_word[uart_pkg::IE_TX] = ie_tx;
  end

  always_comb begin
    data_out = '0;
    if (rd_acc) data_out = address ? ident_word : status_word;
  end

  assign interrupt[0] = ie_rx & ~rx_empty;
  assign interrupt[1] = ie_tx & tx_idle;

endmodule

`default_nettype wire

//--- verilog/uart_top.sv
`default_nettype none

`include "uart_settings.svh"

module uart_top (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        rx,
  output logic             tx,
  input  wire logic        select,
  input  wire logic        write,
  input  wire logic        address,
  input  wire logic [3:0]  be,
  input  wire logic [31:0] data_in,
  output logic      [31:0] data_out,
  output logic      [1:0]  interrupt
);

  logic [7:0]          tx_head;
  logic                tx_empty;
  logic                tx_full;
  logic                tx_push;
  logic                tx_pop;
  logic [7:0]          tx_wdata;
  uart_pkg::rx_entry_t rx_head;
  logic                rx_empty;
  logic                rx_full;
  logic                rx_push;
  logic                rx_pop;
  uart_pkg::rx_entry_t rx_wdata;
  logic                tx_ready;
  logic                tx_start;
  logic                rx_strobe;
  uart_pkg::rx_entry_t rx_entry;

  // --------------------------------------------------
  // register block and buffers
  // --------------------------------------------------

  uart_regs i_regs (
    .clk(clk), .rst_n(rst_n), .select(select), .write(write), .address(address),
    .be(be), .data_in(data_in), .data_out(data_out), .interrupt(interrupt),
    .tx_head(tx_head), .tx_empty(tx_empty), .tx_full(tx_full), .tx_push(tx_push),
    .tx_pop(tx_pop), .tx_wdata(tx_wdata), .rx_head(rx_head), .rx_empty(rx_empty),
    .rx_full(rx_full), .rx_push(rx_push), .rx_pop(rx_pop), .rx_wdata(rx_wdata),
    .tx_ready(tx_ready), .tx_start(tx_start), .rx_strobe(rx_strobe), .rx_entry(rx_entry)
  );

  uart_fifo #(.payload_t(logic [7:0]), .DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
    .clk(clk), .rst_n(rst_n), .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
    .head(tx_head), .empty(tx_empty), .full(tx_full)
  );

  uart_fifo #(.payload_t(uart_pkg::rx_entry_t), .DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
    .clk(clk), .rst_n(rst_n), .push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
    .head(rx_head), .empty(rx_empty), .full(rx_full)
  );

  // --------------------------------------------------
  // serial engines
  // --------------------------------------------------

  uart_tx #(.CLKFREQ(`UART_CLKFREQ), .BAUD(`UART_BAUD)) i_tx (
    .clk(clk), .rst_n(rst_n), .start(tx_start), .data(tx_head), .ready(tx_ready), .tx(tx)
  );

  uart_rx #(.CLKFREQ(`UART_CLKFREQ), .BAUD(`UART_BAUD)) i_rx (
    .clk(clk), .rst_n(rst_n), .rx(rx), .strobe(rx_strobe), .entry(rx_entry)
  );

endmodule

`default_nettype wire

//--- verif/uart_tb.sv
`default_nettype none

`include "uart_settings.svh"

module uart_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH      = `UART_FIFO_DEPTH;
  localparam int BIT_CYCLES = `UART_CLKFREQ / `UART_BAUD;
  localparam int N_FRAMES   = 2 * (DEPTH + 1) + 3 * DEPTH + 1 + (DEPTH + 2) + 2;
  localparam int WATCHDOG   = N_FRAMES * 10 * BIT_CYCLES * 4 + 4000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        rx;
  logic        tx;
  logic        select;
  logic        write;
  logic        address;
  logic [3:0]  be;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic [1:0]  interrupt;

  logic [7:0]          exp_tx [$]; // bytes accepted but not yet seen on tx.
  uart_pkg::rx_entry_t exp_rx [$];
  logic                model_ovf;
  logic                model_ie_rx;
  logic                model_ie_tx;

  uart_top i_dut (
    .clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx), .select(select), .write(write),
    .address(address), .be(be), .data_in(data_in), .data_out(data_out),
    .interrupt(interrupt)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------
  // checking and bus access
  // --------------------------------------------------

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic bus_write(input logic addr, input logic [31:0] data);
    @(posedge clk);
    select  <= 1'b1;
    write   <= 1'b1;
    address <= addr;
    be      <= 4'b0001;
    data_in <= data;
    @(posedge clk);
    select  <= 1'b0;
    write   <= 1'b0;
  endtask

  task automatic bus_read(input logic addr, output logic [31:0] data);
    @(posedge clk);
    select  <= 1'b1;
    write   <= 1'b0;
    address <= addr;
    @(negedge clk);
    data = data_out; // read data is combinational within the access cycle.
    @(posedge clk);
    select  <= 1'b0;
  endtask

  function automatic logic [31:0] expected_ident();
    return (`UART_IDENT & 32'hffff_fffc) | {30'd0, model_ie_tx, model_ie_rx};
  endfunction

  task automatic check_irq(input logic tx_idle);
    logic [1:0] expected;
    expected[0] = model_ie_rx && exp_rx.size() != 0;
    expected[1] = model_ie_tx && tx_idle;
    @(negedge clk);
    check_value("interrupt", 32'(interrupt), 32'(expected));
  endtask

  // --------------------------------------------------
  // serial line
  // --------------------------------------------------

  task automatic send_frame(input logic [7:0] data, input logic stop);
    logic [9:0] bits;
    bits = {stop, data, 1'b0};
    @(posedge clk);
    repeat (10) begin
      rx   <= bits[0];
      bits = bits >> 1;
      repeat (BIT_CYCLES) @(posedge clk);
    end
    rx <= 1'b1;
    repeat (4) @(posedge clk); // the line must be high again before the next start bit.
  endtask

  task automatic receive_frame(output logic [7:0] data);
    logic [BIT_CYCLES-1:0] samples;
    int                    bit_i;
    int                    cyc;
    data    = 8'h00;
    samples = '0;
    @(negedge clk);
    while (tx !== 1'b0) @(negedge clk);
    for (bit_i = 0; bit_i < 10; bit_i++) begin
      for (cyc = 0; cyc < BIT_CYCLES; cyc++) begin
        if (bit_i != 0 || cyc != 0) @(negedge clk);
        samples = {tx, samples[BIT_CYCLES-1:1]};
      end
      // every cycle of a bit must match its middle sample.
      check_value("tx", 32'(samples), 32'({BIT_CYCLES{samples[BIT_CYCLES/2]}}));
      if (bit_i == 9) begin
        check_value("tx stop bit", 32'(samples[BIT_CYCLES/2]), 32'h1);
      end else if (bit_i != 0) begin
        data = {samples[BIT_CYCLES/2], data[7:1]};
      end
    end
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  task automatic model_rx_push(input logic [7:0] data, input logic ferr);
    uart_pkg::rx_entry_t e;
    e.data      = data;
    e.frame_err = ferr;
    if (exp_rx.size() < DEPTH) exp_rx.push_back(e);
    else model_ovf = 1'b1;
  endtask

  task automatic read_rx_entry();
    logic [31:0]         st;
    uart_pkg::rx_entry_t expected;
    int                  tries;
    check_irq(1'b1);
    bus_read(1'b0, st);
    tries = 1;
    while (!st[uart_pkg::RX_VALID] && tries < 4 * BIT_CYCLES) begin
      bus_read(1'b0, st);
      tries++;
    end
    if (!st[uart_pkg::RX_VALID] || exp_rx.size() == 0) begin
      $display("receive entry missing or unexpected after %0d status reads", tries);
      abort_run();
    end else begin
      expected = exp_rx.pop_front();
      check_value("RX_DATA", 32'(st[uart_pkg::RX_DATA_MSB:uart_pkg::RX_DATA_LSB]),
                  32'(expected.data));
      check_value("RX_FERR", 32'(st[uart_pkg::RX_FERR]), 32'(expected.frame_err));
      check_value("RX_OVF", 32'(st[uart_pkg::RX_OVF]), 32'(model_ovf));
    end
  endtask

  task automatic transmit_round();
    logic [31:0] st;
    logic [7:0]  b;
    logic [7:0]  got;
    int          pending;
    fork
      repeat (DEPTH + 1) begin
        receive_frame(got);
        check_value("tx byte", 32'(got), 32'(exp_tx.pop_front()));
      end
      begin
        b = 8'($urandom);
        bus_write(1'b0, 32'(b));
        exp_tx.push_back(b);
        @(negedge clk);
        while (tx !== 1'b0) @(negedge clk);
        pending = 0; // queued bytes behind the frame on the line.
        repeat (DEPTH + 1) begin
          bus_read(1'b0, st);
          check_value("TX_FULL", 32'(st[uart_pkg::TX_FULL]), 32'(pending == DEPTH));
          check_value("TX_IDLE", 32'(st[uart_pkg::TX_IDLE]), 32'h0);
          if (pending < DEPTH) begin
            b = 8'($urandom);
            bus_write(1'b0, 32'(b));
            exp_tx.push_back(b);
            pending++;
          end
        end
        bus_write(1'b0, $urandom); // dropped by the full fifo.
      end
    join
    bus_read(1'b0, st);
    check_value("TX_IDLE", 32'(st[uart_pkg::TX_IDLE]), 32'h1);
    check_value("TX_FULL", 32'(st[uart_pkg::TX_FULL]), 32'h0);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin
    logic [31:0] st;
    logic [7:0]  b;
    logic [7:0]  got;
    int          n;
    void'($urandom(32'h8d67));
    rst_n       = 1'b0;
    rx          = 1'b1;
    select      = 1'b0;
    write       = 1'b0;
    address     = 1'b0;
    be          = 4'b0000;
    data_in     = 32'h0;
    model_ovf   = 1'b0;
    model_ie_rx = 1'b0;
    model_ie_tx = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_value("tx", 32'(tx), 32'h1);
    check_irq(1'b1);
    bus_read(1'b0, st);
    check_value("RX_VALID", 32'(st[uart_pkg::RX_VALID]), 32'h0);
    check_value("TX_IDLE", 32'(st[uart_pkg::TX_IDLE]), 32'h1);
    check_value("TX_FULL", 32'(st[uart_pkg::TX_FULL]), 32'h0);
    check_value("RX_OVF", 32'(st[uart_pkg::RX_OVF]), 32'h0);
    check_value("status upper bits", 32'(st[31:13]), 32'h0);
    bus_read(1'b1, st);
    check_value("ident", st, expected_ident());

    repeat (2) transmit_round();

    repeat (3) begin
      n = 1 + int'($urandom % DEPTH);
      repeat (n) begin
        b = 8'($urandom);
        send_frame(b, 1'b1);
        model_rx_push(b, 1'b0);
      end
      repeat (n) read_rx_entry();
      bus_read(1'b0, st);
      check_value("RX_VALID", 32'(st[uart_pkg::RX_VALID]), 32'h0);
    end

    b = 8'($urandom);
    send_frame(b, 1'b0); // stop bit low.
    model_rx_push(b, 1'b1);
    read_rx_entry();

    repeat (DEPTH + 2) begin
      b = 8'($urandom);
      send_frame(b, 1'b1);
      model_rx_push(b, 1'b0);
    end
    repeat (DEPTH) read_rx_entry();
    bus_read(1'b0, st);
    check_value("RX_VALID", 32'(st[uart_pkg::RX_VALID]), 32'h0);
    check_value("RX_OVF", 32'(st[uart_pkg::RX_OVF]), 32'h1);
    bus_write(1'b1, 32'h1 << uart_pkg::OVF_CLR);
    model_ovf = 1'b0;
    bus_read(1'b0, st);
    check_value("RX_OVF", 32'(st[uart_pkg::RX_OVF]), 32'h0);

    bus_write(1'b1, 32'h1 << uart_pkg::IE_RX);
    model_ie_rx = 1'b1;
    bus_read(1'b1, st);
    check_value("ident", st, expected_ident());
    check_irq(1'b1);
    b = 8'($urandom);
    send_frame(b, 1'b1);
    model_rx_push(b, 1'b0);
    check_irq(1'b1);
    read_rx_entry();
    check_irq(1'b1);

    bus_write(1'b1, 32'h1 << uart_pkg::IE_TX);
    model_ie_rx = 1'b0;
    model_ie_tx = 1'b1;
    bus_read(1'b1, st);
    check_value("ident", st, expected_ident());
    check_irq(1'b1);
    b = 8'($urandom);
    bus_write(1'b0, 32'(b));
    exp_tx.push_back(b);
    check_irq(1'b0);
    receive_frame(got);
    check_value("tx byte", 32'(got), 32'(exp_tx.pop_front()));
    check_irq(1'b1);
    bus_write(1'b1, 32'h0);
    model_ie_tx = 1'b0;
    check_irq(1'b1);

    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG);
    abort_run();
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/uart_pkg.sv
verilog/uart_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_regs.sv
verilog/uart_top.sv
verif/uart_tb.sv

//--- run.sh
#!/bin/sh
# Build the UART testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timescale 1ns/100ps --top-module uart_tb -f src.f -o uart_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/uart_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
